//--- alex_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module alex_axil_regs
(
  input  logic                             aclk,
  input  logic                             aresetn,

  input  logic [alex_pkg::ADDR_W-1:0]      awaddr,
  input  logic                             awvalid,
  output logic                             awready,
  input  logic [alex_pkg::DATA_W-1:0]      wdata,
  input  logic [alex_pkg::DATA_W/8-1:0]    wstrb,
  input  logic                             wvalid,
  output logic                             wready,
  output logic [1:0]                       bresp,
  output logic                             bvalid,
  input  logic                             bready,

  input  logic [alex_pkg::ADDR_W-1:0]      araddr,
  input  logic                             arvalid,
  output logic                             arready,
  output logic [alex_pkg::DATA_W-1:0]      rdata,
  output logic [1:0]                       rresp,
  output logic                             rvalid,
  input  logic                             rready,

  input  logic                             tx_busy,
  input  logic                             rx_busy,
  output logic [alex_pkg::WORD_BITS-1:0]   tx_word,
  output logic [alex_pkg::WORD_BITS-1:0]   rx_word,
  output logic                             tx_wr,
  output logic                             rx_wr
);

  logic [alex_pkg::WORD_BITS-1:0] tx_word_q;
  logic [alex_pkg::WORD_BITS-1:0] rx_word_q;
  logic [alex_pkg::WORD_BITS-1:0] tx_merged;
  logic [alex_pkg::WORD_BITS-1:0] rx_merged;
  logic                           wr_accept;
  logic                           wr_lane;
  logic                           hit_tx;
  logic                           hit_rx;
  logic                           rd_accept;

  // Byte lanes 0 and 1 update on their own.
  function automatic logic [alex_pkg::WORD_BITS-1:0] merge_lanes(
    input logic [alex_pkg::WORD_BITS-1:0] old_word,
    input logic [alex_pkg::DATA_W-1:0]    data,
    input logic [1:0]                     strb
  );
    logic [alex_pkg::WORD_BITS-1:0] res;
    res = old_word;
    if (strb[0])
      res[7:0] = data[7:0];
    if (strb[1])
      res[15:8] = data[15:8];
    return res;
  endfunction

  // ------------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------------
  assign awready   = awvalid & wvalid & ~bvalid;  // Address and data taken together.
  assign wready    = awready;
  assign wr_accept = awready;
  assign wr_lane   = |wstrb[1:0];

  assign hit_tx = wr_accept && (awaddr == alex_pkg::REG_TX_WORD);
  assign hit_rx = wr_accept && (awaddr == alex_pkg::REG_RX_WORD);

  assign tx_merged = merge_lanes(tx_word_q, wdata, wstrb[1:0]);
  assign rx_merged = merge_lanes(rx_word_q, wdata, wstrb[1:0]);

  assign tx_wr = hit_tx & wr_lane;
  assign rx_wr = hit_rx & wr_lane;

  // The shifter samples the new value in the strobe cycle.
  assign tx_word = tx_wr ? tx_merged : tx_word_q;
  assign rx_word = rx_wr ? rx_merged : rx_word_q;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      tx_word_q <= '0;
      rx_word_q <= '0;
      bvalid    <= 1'b0;
    end
    else
    begin
      if (tx_wr)
        tx_word_q <= tx_merged;
      if (rx_wr)
        rx_word_q <= rx_merged;
      if (wr_accept)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (wr_accept)
      bresp <= (hit_tx | hit_rx) ? alex_pkg::RESP_OKAY : alex_pkg::RESP_SLVERR;
  end

  // ------------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------------
  assign arready   = arvalid & ~rvalid;
  assign rd_accept = arready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      rvalid <= 1'b0;
    else if (rd_accept)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  always_ff @(posedge aclk)
  begin
    if (rd_accept)
    begin
      rresp <= alex_pkg::RESP_OKAY;
      case (araddr)
        alex_pkg::REG_TX_WORD: rdata <= {{(alex_pkg::DATA_W-alex_pkg::WORD_BITS){1'b0}}, tx_word_q};
        alex_pkg::REG_RX_WORD: rdata <= {{(alex_pkg::DATA_W-alex_pkg::WORD_BITS){1'b0}}, rx_word_q};
        alex_pkg::REG_STATUS:  rdata <= {{(alex_pkg::DATA_W-2){1'b0}}, rx_busy, tx_busy};
        default:
        begin
          rdata <= '0;
          rresp <= alex_pkg::RESP_SLVERR;  // Unmapped offset.
        end
      endcase
    end
  end

  // Write response is held until the master takes it.
  a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid);

  a_single_strobe: assert property (@(posedge aclk) disable iff (!aresetn)
    !(tx_wr && rx_wr));

endmodule

`default_nettype wire

//--- alex_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module alex_bus_arbiter
(
  input  logic aclk,
  input  logic aresetn,

  input  logic tx_req,
  input  logic rx_req,
  input  logic tx_done,
  input  logic rx_done,
  output logic tx_grant,
  output logic rx_grant,

  input  logic tx_sdata,
  input  logic tx_sclk,
  input  logic tx_load,
  input  logic rx_sdata,
  input  logic rx_sclk,
  input  logic rx_load,

  output logic alex_sdata,
  output logic alex_sclk,
  output logic alex_tx_load,
  output logic alex_rx_load
);

  typedef enum logic [1:0] {OWN_IDLE, OWN_TX, OWN_RX} owner_t;

  owner_t owner;
  logic   last_rx;  // Last frame served was RX.

  // TX wins a tie unless it went last.
  assign tx_grant = (owner == OWN_IDLE) && tx_req && (!rx_req || last_rx);
  assign rx_grant = (owner == OWN_IDLE) && rx_req && (!tx_req || !last_rx);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      owner   <= OWN_IDLE;
      last_rx <= 1'b1;  // First choice goes to TX.
    end
    else
    begin
      case (owner)
        OWN_IDLE:
        begin
          if (tx_grant)
          begin
            owner   <= OWN_TX;
            last_rx <= 1'b0;
          end
          else if (rx_grant)
          begin
            owner   <= OWN_RX;
            last_rx <= 1'b1;
          end
        end
        OWN_TX:  if (tx_done) owner <= OWN_IDLE;
        OWN_RX:  if (rx_done) owner <= OWN_IDLE;
        default: owner <= OWN_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Pin multiplexer
  // ------------------------------------------------------------------
  always_comb
  begin
    alex_sdata   = 1'b0;
    alex_sclk    = 1'b0;
    alex_tx_load = 1'b0;
    alex_rx_load = 1'b0;
    case (owner)
      OWN_TX:
      begin
        alex_sdata   = tx_sdata;
        alex_sclk    = tx_sclk;
        alex_tx_load = tx_load;
      end
      OWN_RX:
      begin
        alex_sdata   = rx_sdata;
        alex_sclk    = rx_sclk;
        alex_rx_load = rx_load;
      end
      default: ;
    endcase
  end

  a_one_grant: assert property (@(posedge aclk) disable iff (!aresetn)
    !(tx_grant && rx_grant));

endmodule

`default_nettype wire

//--- alex_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module alex_ctrl_top
(
  input  logic                          aclk,
  input  logic                          aresetn,

  input  logic [alex_pkg::ADDR_W-1:0]   awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [alex_pkg::DATA_W-1:0]   wdata,
  input  logic [alex_pkg::DATA_W/8-1:0] wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [alex_pkg::ADDR_W-1:0]   araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [alex_pkg::DATA_W-1:0]   rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready,

  output logic                          alex_sdata,
  output logic                          alex_sclk,
  output logic                          alex_tx_load,
  output logic                          alex_rx_load
);

  logic [alex_pkg::WORD_BITS-1:0] tx_word, rx_word;
  logic tx_wr, rx_wr;
  logic tx_req, rx_req;
  logic tx_grant, rx_grant;
  logic tx_busy, rx_busy;
  logic tx_done, rx_done;
  logic tx_sdata, tx_sclk, tx_load;
  logic rx_sdata, rx_sclk, rx_load;

  alex_axil_regs u_regs (
    .aclk(aclk), .aresetn(aresetn),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .tx_busy(tx_busy), .rx_busy(rx_busy),
    .tx_word(tx_word), .rx_word(rx_word), .tx_wr(tx_wr), .rx_wr(rx_wr)
  );

  // Transmit path.
  alex_frame_shifter u_tx_shifter (
    .aclk(aclk), .aresetn(aresetn),
    .word(tx_word), .wr(tx_wr), .grant(tx_grant),
    .req(tx_req), .busy(tx_busy), .done(tx_done),
    .sdata(tx_sdata), .sclk(tx_sclk), .load(tx_load)
  );

  // Receive path.
  alex_frame_shifter u_rx_shifter (
    .aclk(aclk), .aresetn(aresetn),
    .word(rx_word), .wr(rx_wr), .grant(rx_grant),
    .req(rx_req), .busy(rx_busy), .done(rx_done),
    .sdata(rx_sdata), .sclk(rx_sclk), .load(rx_load)
  );

  alex_bus_arbiter u_arbiter (
    .aclk(aclk), .aresetn(aresetn),
    .tx_req(tx_req), .rx_req(rx_req), .tx_done(tx_done), .rx_done(rx_done),
    .tx_grant(tx_grant), .rx_grant(rx_grant),
    .tx_sdata(tx_sdata), .tx_sclk(tx_sclk), .tx_load(tx_load),
    .rx_sdata(rx_sdata), .rx_sclk(rx_sclk), .rx_load(rx_load),
    .alex_sdata(alex_sdata), .alex_sclk(alex_sclk),
    .alex_tx_load(alex_tx_load), .alex_rx_load(alex_rx_load)
  );

endmodule

`default_nettype wire

//--- alex_frame_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module alex_frame_shifter
(
  input  logic                           aclk,
  input  logic                           aresetn,

  input  logic [alex_pkg::WORD_BITS-1:0] word,
  input  logic                           wr,
  input  logic                           grant,

  output logic                           req,
  output logic                           busy,
  output logic                           done,
  output logic                           sdata,
  output logic                           sclk,
  output logic                           load
);

  logic [alex_pkg::WORD_BITS-1:0]   pend_word;
  logic [alex_pkg::WORD_BITS-1:0]   shift_q;
  logic [alex_pkg::FRAME_CNT_W-1:0] cnt;
  logic [alex_pkg::FRAME_CNT_W-1:0] phase;
  logic                             running;
  logic                             in_data;
  logic                             bit_end;
  logic                             frame_end;

  // Position inside the current bit period.
  assign phase = cnt % alex_pkg::FRAME_CNT_W'(alex_pkg::BIT_CYCLES);

  assign in_data   = cnt < alex_pkg::FRAME_CNT_W'(alex_pkg::WORD_BITS * alex_pkg::BIT_CYCLES);
  assign bit_end   = phase == alex_pkg::FRAME_CNT_W'(alex_pkg::BIT_CYCLES - 1);
  assign frame_end = cnt == alex_pkg::FRAME_CNT_W'(alex_pkg::FRAME_CYCLES - 1);

  // ------------------------------------------------------------------
  // Request and frame counter
  // ------------------------------------------------------------------
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      req     <= 1'b0;
      running <= 1'b0;
      cnt     <= '0;
    end
    else
    begin
      if (grant)
        req <= 1'b0;
      if (wr)
        req <= 1'b1;  // A write in the grant cycle stays pending.

      if (grant)
      begin
        running <= 1'b1;
        cnt     <= '0;
      end
      else if (running)
      begin
        if (frame_end)
        begin
          running <= 1'b0;
          cnt     <= '0;
        end
        else
        begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // Latest word wins while pending.
  always_ff @(posedge aclk)
  begin
    if (wr)
      pend_word <= word;

    if (grant)
      shift_q <= pend_word;
    else if (running && bit_end)
      shift_q <= {1'b0, shift_q[alex_pkg::WORD_BITS-1:1]};  // LSB first.
  end

  // ------------------------------------------------------------------
  // Pin decode
  // ------------------------------------------------------------------
  assign sdata = running & in_data & shift_q[0];
  assign sclk  = running & in_data & (phase >= alex_pkg::FRAME_CNT_W'(alex_pkg::SCLK_HIGH_START));
  assign load  = running & (cnt >= alex_pkg::FRAME_CNT_W'(alex_pkg::LOAD_START));
  assign done  = running & frame_end;
  assign busy  = req | running;

  a_no_grant_in_frame: assert property (@(posedge aclk) disable iff (!aresetn)
    grant |-> !running);

endmodule

`default_nettype wire

//--- alex_pkg.sv
`default_nettype none

package alex_pkg;

  // ------------------------------------------------------------------
  // Frame timing, in aclk cycles.
  // ------------------------------------------------------------------
  localparam int unsigned WORD_BITS       = 16;
  localparam int unsigned BIT_CYCLES      = 128;
  localparam int unsigned SCLK_HIGH_START = 64;   // Serial clock rises mid-bit.
  localparam int unsigned LOAD_START      = 2112;
  localparam int unsigned FRAME_CYCLES    = 2176;
  localparam int unsigned FRAME_CNT_W     = 12;

  // ------------------------------------------------------------------
  // AXI4-Lite register map.
  // ------------------------------------------------------------------
  localparam int unsigned ADDR_W = 4;
  localparam int unsigned DATA_W = 32;

  localparam logic [ADDR_W-1:0] REG_TX_WORD = 4'h0;
  localparam logic [ADDR_W-1:0] REG_RX_WORD = 4'h4;
  localparam logic [ADDR_W-1:0] REG_STATUS  = 4'h8;  // Bit 0 tx busy, bit 1 rx busy.

  // Response codes.
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- files.f
alex_pkg.sv
alex_axil_regs.sv
alex_frame_shifter.sv
alex_bus_arbiter.sv
alex_ctrl_top.sv
tb_alex_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Alex controller testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_alex_ctrl -f files.f -o sim_alex

# The log decides the result, so a failing run still reaches the search.
./obj_dir/sim_alex > sim.log 2>&1 || true
cat sim.log

grep -q "Simulation PASSED" sim.log
echo "Run passed"

//--- tb_alex_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alex_ctrl;

  localparam int CLK_PERIOD = 8;
  localparam int MAX_FRAMES = 30;     // Upper bound on frames over all tests.
  localparam int MARGIN_NS  = 20000;
  localparam int N_RANDOM   = 20;

  logic                          aclk;
  logic                          aresetn;
  logic [alex_pkg::ADDR_W-1:0]   awaddr;
  logic                          awvalid;
  logic                          awready;
  logic [alex_pkg::DATA_W-1:0]   wdata;
  logic [alex_pkg::DATA_W/8-1:0] wstrb;
  logic                          wvalid;
  logic                          wready;
  logic [1:0]                    bresp;
  logic                          bvalid;
  logic                          bready;
  logic [alex_pkg::ADDR_W-1:0]   araddr;
  logic                          arvalid;
  logic                          arready;
  logic [alex_pkg::DATA_W-1:0]   rdata;
  logic [1:0]                    rresp;
  logic                          rvalid;
  logic                          rready;
  logic                          alex_sdata;
  logic                          alex_sclk;
  logic                          alex_tx_load;
  logic                          alex_rx_load;

  int          cyc = 0;
  int          errors = 0;
  int          err_mark = 0;
  int          n_checked = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  bit          stall_en = 1'b0;
  string       test_name = "reset";
  logic [15:0] model_word [2];
  int          wr_cycle [$];      // Write history seen by the shifters.
  bit          wr_path [$];
  logic [15:0] wr_word [$];
  logic [15:0] mon_shift = '0;
  int          mon_bits = 0;
  logic [17:0] got_q [$];         // {16 pulses seen, rx line, word}.
  logic [17:0] got_f;
  logic [17:0] exp_f;

  alex_ctrl_top u_alex_ctrl_top (.*);

  initial
  begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  always @(posedge aclk)
    cyc <= cyc + 1;

  function automatic void check_value(input string what, input logic [31:0] exp,
                                      input logic [31:0] act);
    if (exp !== act)
    begin
      $display("MISMATCH %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
      errors++;
    end
  endfunction

  // ------------------------------------------------------------------
  // Reference model. Returns frame idx as {valid, rx, word}.
  // ------------------------------------------------------------------
  function automatic logic [17:0] expected_frame(input int idx);
    bit          pv [2];
    logic [15:0] pw [2];
    logic [17:0] res;
    int          i;
    int          nfr;
    int          g;
    int          free_at;
    bit          last_rx;
    bit          sel;
    bit          fin;
    pv[0] = 1'b0;
    pv[1] = 1'b0;
    pw[0] = '0;
    pw[1] = '0;
    res = '0;
    i = 0;
    nfr = 0;
    free_at = 0;
    last_rx = 1'b1;               // TX goes first after reset.
    fin = 1'b0;
    while (!fin)
    begin
      g = free_at;
      if (!pv[0] && !pv[1] && i < wr_cycle.size() && wr_cycle[i] + 1 > g)
        g = wr_cycle[i] + 1;      // Request shows up the cycle after the strobe.
      while (i < wr_cycle.size() && wr_cycle[i] < g)
      begin
        pv[wr_path[i]] = 1'b1;
        pw[wr_path[i]] = wr_word[i];  // Latest word wins.
        i++;
      end
      if (!pv[0] && !pv[1])
        fin = 1'b1;
      else
      begin
        if (pv[0] && pv[1])
          sel = !last_rx;         // Both waiting, so the grant alternates.
        else
          sel = pv[1];
        if (nfr == idx)
        begin
          res = {1'b1, sel, pw[sel]};
          fin = 1'b1;
        end
        pv[sel] = 1'b0;
        last_rx = sel;
        nfr++;
        free_at = g + alex_pkg::FRAME_CYCLES + 1;
      end
    end
    return res;
  endfunction

  function automatic int count_frames();
    logic [17:0] f;
    int          n;
    n = 0;
    f = expected_frame(0);
    while (f[17])
    begin
      n++;
      f = expected_frame(n);
    end
    return n;
  endfunction

  // ------------------------------------------------------------------
  // Pin monitor and compare process
  // ------------------------------------------------------------------
  always @(posedge alex_sclk)
  begin
    mon_shift = {alex_sdata, mon_shift[15:1]};  // LSB arrives first.
    mon_bits++;
  end

  always @(posedge alex_tx_load or posedge alex_rx_load)
  begin
    got_q.push_back({mon_bits == 16, alex_rx_load, mon_shift});
    mon_bits = 0;
  end

  always @(posedge aclk)
  begin
    if (got_q.size() != 0)
    begin
      got_f = got_q.pop_front();
      exp_f = expected_frame(n_checked);
      if (!got_f[17])
      begin
        $display("ERROR %s: frame %0d did not carry 16 serial clock pulses",
                 test_name, n_checked);
        errors++;
      end
      if (!exp_f[17])
      begin
        $display("ERROR %s: frame %0d appeared on the pins but none was expected",
                 test_name, n_checked);
        errors++;
      end
      else
      begin
        check_value("frame load line", {31'b0, exp_f[16]}, {31'b0, got_f[16]});
        check_value("frame word", {16'b0, exp_f[15:0]}, {16'b0, got_f[15:0]});
      end
      n_checked++;
    end
  end

  // ------------------------------------------------------------------
  // Bus tasks
  // ------------------------------------------------------------------
  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge aclk);
      #1;
    end
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    bit taken;
    bit is_word;
    bit path;
    is_word = (addr == alex_pkg::REG_TX_WORD) || (addr == alex_pkg::REG_RX_WORD);
    path    = (addr == alex_pkg::REG_RX_WORD);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    taken   = 1'b0;
    while (!taken)
    begin
      #1;
      taken = awready && wready;
      idle_cycles(1);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (is_word && strb[1:0] != 2'b00)
    begin
      if (strb[0])
        model_word[path][7:0] = data[7:0];
      if (strb[1])
        model_word[path][15:8] = data[15:8];
      wr_cycle.push_back(cyc);
      wr_path.push_back(path);
      wr_word.push_back(model_word[path]);
    end
    taken = 1'b0;
    while (!taken)
    begin
      bready = stall_en ? 1'($urandom_range(0, 1)) : 1'b1;
      #1;
      taken = bvalid && bready;
      resp  = bresp;
      idle_cycles(1);
    end
    bready = 1'b0;
    check_value("bresp", {30'b0, is_word ? alex_pkg::RESP_OKAY : alex_pkg::RESP_SLVERR},
                {30'b0, resp});
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    bit taken;
    bit mapped;
    mapped  = (addr == alex_pkg::REG_TX_WORD) || (addr == alex_pkg::REG_RX_WORD) ||
              (addr == alex_pkg::REG_STATUS);
    araddr  = addr;
    arvalid = 1'b1;
    taken   = 1'b0;
    while (!taken)
    begin
      #1;
      taken = arready;
      idle_cycles(1);
    end
    arvalid = 1'b0;
    taken   = 1'b0;
    while (!taken)
    begin
      rready = stall_en ? 1'($urandom_range(0, 1)) : 1'b1;
      #1;
      taken = rvalid && rready;
      data  = rdata;
      resp  = rresp;
      idle_cycles(1);
    end
    rready = 1'b0;
    check_value("rresp", {30'b0, mapped ? alex_pkg::RESP_OKAY : alex_pkg::RESP_SLVERR},
                {30'b0, resp});
  endtask

  // Waits until every predicted frame was decoded and the load line fell.
  task automatic wait_frames();
    int target;
    target = count_frames();
    while (n_checked < target || alex_tx_load || alex_rx_load)
      idle_cycles(1);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test();
    if (errors == err_mark)
    begin
      $display("PASS %s", test_name);
      n_pass++;
    end
    else
    begin
      $display("FAIL %s with %0d errors", test_name, errors - err_mark);
      n_fail++;
    end
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial
  begin
    logic [31:0] rd;
    logic [1:0]  resp;
    bit          path_sel;
    void'($urandom(69));
    aresetn = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    model_word[0] = '0;
    model_word[1] = '0;
    repeat (2) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    start_test("reset_values");
    check_value("pins", 32'h0, {28'h0, alex_sdata, alex_sclk, alex_tx_load, alex_rx_load});
    read_reg(alex_pkg::REG_STATUS, rd, resp);
    check_value("status", 32'h0, rd);
    read_reg(alex_pkg::REG_TX_WORD, rd, resp);
    check_value("tx word", 32'h0, rd);
    read_reg(alex_pkg::REG_RX_WORD, rd, resp);
    check_value("rx word", 32'h0, rd);
    end_test();

    start_test("single_write");
    write_reg(alex_pkg::REG_TX_WORD, $urandom, 4'hF, resp);
    wait_frames();
    write_reg(alex_pkg::REG_RX_WORD, $urandom, 4'hF, resp);
    wait_frames();
    end_test();

    start_test("back_to_back");
    write_reg(alex_pkg::REG_TX_WORD, $urandom, 4'hF, resp);
    write_reg(alex_pkg::REG_RX_WORD, $urandom, 4'hF, resp);
    wait_frames();
    end_test();

    start_test("latest_wins");
    write_reg(alex_pkg::REG_TX_WORD, $urandom, 4'hF, resp);
    idle_cycles(200);  // Well inside the first frame.
    write_reg(alex_pkg::REG_TX_WORD, $urandom, 4'hF, resp);
    write_reg(alex_pkg::REG_TX_WORD, $urandom, 4'hF, resp);
    read_reg(alex_pkg::REG_STATUS, rd, resp);
    check_value("status tx busy", 32'h1, {31'b0, rd[0]});
    wait_frames();
    read_reg(alex_pkg::REG_STATUS, rd, resp);
    check_value("status after frames", 32'h0, rd);
    end_test();

    start_test("slverr_and_lanes");
    write_reg(4'hC, $urandom, 4'hF, resp);
    read_reg(4'hC, rd, resp);
    check_value("unmapped rdata", 32'h0, rd);
    read_reg(alex_pkg::REG_TX_WORD, rd, resp);
    check_value("tx word kept", {16'h0, model_word[0]}, rd);
    read_reg(alex_pkg::REG_RX_WORD, rd, resp);
    check_value("rx word kept", {16'h0, model_word[1]}, rd);
    write_reg(alex_pkg::REG_TX_WORD, $urandom, 4'b0001, resp);
    read_reg(alex_pkg::REG_TX_WORD, rd, resp);
    check_value("tx low byte only", {16'h0, model_word[0]}, rd);
    wait_frames();
    end_test();

    start_test("random_traffic");
    stall_en = 1'b1;
    for (int i = 0; i < N_RANDOM; i++)
    begin
      path_sel = 1'($urandom_range(0, 1));
      write_reg(path_sel ? alex_pkg::REG_RX_WORD : alex_pkg::REG_TX_WORD, $urandom, 4'hF, resp);
      if ($urandom_range(0, 3) == 0)
      begin
        read_reg(path_sel ? alex_pkg::REG_RX_WORD : alex_pkg::REG_TX_WORD, rd, resp);
        check_value("readback", {16'h0, model_word[path_sel]}, rd);
      end
      idle_cycles(int'($urandom_range(0, alex_pkg::FRAME_CYCLES)));
    end
    stall_en = 1'b0;
    wait_frames();
    end_test();

    test_name = "final";
    check_value("frames decoded", count_frames(), n_checked);
    $display("Tests passed %0d, failed %0d, frames checked %0d, errors %0d",
             n_pass, n_fail, n_checked, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    #(MAX_FRAMES * alex_pkg::FRAME_CYCLES * CLK_PERIOD * 2 + MARGIN_NS);
    $display("ERROR: watchdog expired in %s, the DUT stopped producing frames", test_name);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
